//--- Makefile
# Verilator build and run of the global controller testbench

SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      := tb_global_controller
FILELIST := sim.f
OBJ_DIR  := obj_dir
PASS_MSG := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up as a line of its own
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim.f
src/dram_cmd_pkg.sv
src/gc_sched_pkg.sv
src/read_queue.sv
src/write_buffer.sv
src/request_scheduler.sv
src/bank_dispatch.sv
src/global_controller.sv
tb/tb_global_controller.sv

//--- src/bank_dispatch.sv
/*
 * Final register stage toward the four bank controllers.
 * Command and data are shared, the valid strobe selects the bank.
 */

`timescale 1ns/100ps

module bank_dispatch #(
    parameter int DATA_W = 64
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_issue_valid,
    input  dram_cmd_pkg::dram_cmd_t  i_issue_cmd,
    input  logic [DATA_W-1:0]       i_issue_wdata,
    output gc_sched_pkg::bank_mask_t o_bank_valid,
    output dram_cmd_pkg::dram_cmd_t  o_bank_cmd,
    output logic [DATA_W-1:0]       o_bank_wdata
);

    gc_sched_pkg::bank_mask_t valid_d;

    // bank field to one-hot strobe
    assign valid_d = i_issue_valid ? (gc_sched_pkg::bank_mask_t'(1) << i_issue_cmd.bank) : '0;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_bank_valid <= '0;
        end
        else
        begin
            o_bank_valid <= valid_d;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_issue_valid)
        begin
            o_bank_cmd   <= i_issue_cmd;
            o_bank_wdata <= i_issue_wdata;
        end
    end

    // strobe must point at the bank named in the shared command
    a_valid_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(o_bank_valid) && ((o_bank_valid == '0) || o_bank_valid[o_bank_cmd.bank]));

endmodule

//--- src/dram_cmd_pkg.sv
/*
 * Command format shared by the controller front end and its testbench.
 * A command carries its op and the full bank, row and column address.
 */

package dram_cmd_pkg;

    ////////////////////////////////////////////////////////////
    // address field widths
    ////////////////////////////////////////////////////////////
    localparam int BANK_W    = 2;
    localparam int ROW_W     = 14;
    localparam int COL_W     = 10;
    localparam int NUM_BANKS = 4;

    typedef logic [BANK_W-1:0] bank_addr_t;
    typedef logic [ROW_W-1:0]  row_addr_t;
    typedef logic [COL_W-1:0]  col_addr_t;

    // bank, row and column joined for the hazard compare
    typedef logic [BANK_W+ROW_W+COL_W-1:0] dram_addr_t;

    ////////////////////////////////////////////////////////////
    // command op and format
    ////////////////////////////////////////////////////////////
    typedef logic [0:0] dram_op_t;

    localparam dram_op_t OP_READ  = 1'b0;
    localparam dram_op_t OP_WRITE = 1'b1;

    typedef struct packed {
        dram_op_t   op;
        bank_addr_t bank;
        row_addr_t  row;
        col_addr_t  col;
    } dram_cmd_t;

endpackage

//--- src/gc_sched_pkg.sv
/*
 * Scheduler mode and per-bank mask types of the global controller.
 * The mask carries one bit per bank controller.
 */

package gc_sched_pkg;

    // reads go first until a flush is requested
    typedef enum logic [0:0] {
        READ_FIRST  = 1'b0,
        WRITE_FLUSH = 1'b1
    } sched_mode_e;

    // bank ready and bank valid
    typedef logic [dram_cmd_pkg::NUM_BANKS-1:0] bank_mask_t;

endpackage

//--- src/global_controller.sv
/*
 * Front end of the DRAM global controller.
 * Accepts requests on a valid/ready handshake, queues reads and writes
 * apart and dispatches each command to the controller of its bank.
 */

`timescale 1ns/100ps

module global_controller #(
    parameter int DATA_W      = 64,
    parameter int RD_DEPTH    = 8,
    parameter int WR_DEPTH    = 8,
    parameter int FLUSH_LEVEL = 4
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_req_valid,
    input  dram_cmd_pkg::dram_cmd_t  i_req_cmd,
    input  logic [DATA_W-1:0]       i_req_wdata,
    output logic                    o_req_ready,
    input  gc_sched_pkg::bank_mask_t i_bank_ready,
    output gc_sched_pkg::bank_mask_t o_bank_valid,
    output dram_cmd_pkg::dram_cmd_t  o_bank_cmd,
    output logic [DATA_W-1:0]       o_bank_wdata
);

    logic                     accept;
    logic                     is_read;
    logic                     rd_push;
    logic                     wr_push;
    dram_cmd_pkg::dram_addr_t probe_addr;
    dram_cmd_pkg::dram_cmd_t  rd_head;
    dram_cmd_pkg::dram_cmd_t  wr_head;
    logic [DATA_W-1:0]        wr_head_wdata;
    logic                     rd_empty;
    logic                     rd_full;
    logic                     wr_empty;
    logic                     wr_full;
    logic                     flush_req;
    logic                     rd_pop;
    logic                     wr_pop;
    logic                     flushing;
    logic                     issue_valid;
    dram_cmd_pkg::dram_cmd_t  issue_cmd;
    logic [DATA_W-1:0]        issue_wdata;

    ////////////////////////////////////////////////////////////
    // request acceptance
    ////////////////////////////////////////////////////////////
    assign o_req_ready = !rd_full && !wr_full && !flushing;
    assign accept      = i_req_valid && o_req_ready;
    assign is_read     = (i_req_cmd.op == dram_cmd_pkg::OP_READ);
    assign rd_push     = accept && is_read;
    assign wr_push     = accept && !is_read;
    assign probe_addr  = {i_req_cmd.bank, i_req_cmd.row, i_req_cmd.col};

    read_queue #(.DEPTH(RD_DEPTH)) u_read_queue (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_push(rd_push), .i_cmd(i_req_cmd), .i_pop(rd_pop),
        .o_head(rd_head), .o_empty(rd_empty), .o_full(rd_full)
    );

    write_buffer #(.DEPTH(WR_DEPTH), .DATA_W(DATA_W), .FLUSH_LEVEL(FLUSH_LEVEL)) u_write_buffer (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_push(wr_push), .i_cmd(i_req_cmd), .i_wdata(i_req_wdata),
        .i_read_probe(rd_push), .i_probe_addr(probe_addr), .i_pop(wr_pop),
        .o_head(wr_head), .o_head_wdata(wr_head_wdata),
        .o_empty(wr_empty), .o_full(wr_full), .o_flush_req(flush_req)
    );

    request_scheduler #(.DATA_W(DATA_W)) u_request_scheduler (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_rd_head(rd_head), .i_rd_empty(rd_empty),
        .i_wr_head(wr_head), .i_wr_head_wdata(wr_head_wdata), .i_wr_empty(wr_empty),
        .i_flush_req(flush_req), .i_bank_ready(i_bank_ready),
        .o_rd_pop(rd_pop), .o_wr_pop(wr_pop), .o_flushing(flushing),
        .o_issue_valid(issue_valid), .o_issue_cmd(issue_cmd), .o_issue_wdata(issue_wdata)
    );

    bank_dispatch #(.DATA_W(DATA_W)) u_bank_dispatch (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_issue_valid(issue_valid), .i_issue_cmd(issue_cmd), .i_issue_wdata(issue_wdata),
        .o_bank_valid(o_bank_valid), .o_bank_cmd(o_bank_cmd), .o_bank_wdata(o_bank_wdata)
    );

endmodule

//--- src/read_queue.sv
/*
 * Circular FIFO of read commands waiting for the scheduler.
 * The head is valid whenever o_empty is low.
 */

`timescale 1ns/100ps

module read_queue #(
    parameter int DEPTH = 8
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_push,
    input  dram_cmd_pkg::dram_cmd_t i_cmd,
    input  logic                   i_pop,
    output dram_cmd_pkg::dram_cmd_t o_head,
    output logic                   o_empty,
    output logic                   o_full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    dram_cmd_pkg::dram_cmd_t mem [DEPTH];
    logic [PTR_W-1:0]        rd_ptr_q;
    logic [PTR_W-1:0]        wr_ptr_q;
    logic [CNT_W-1:0]        count_q;

    // command storage
    always_ff @(posedge i_clk)
    begin
        if (i_push)
        begin
            mem[wr_ptr_q] <= i_cmd;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (i_push)
            begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (i_pop)
            begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(i_push) - CNT_W'(i_pop);
        end
    end

    assign o_head  = mem[rd_ptr_q];
    assign o_empty = (count_q == '0);
    assign o_full  = (count_q == CNT_W'(DEPTH));

    // the top must hold off requests while full
    a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_push |-> !o_full);
    a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pop |-> !o_empty);

endmodule

//--- src/request_scheduler.sv
/*
 * Picks the next command from the read queue or the write buffer.
 * Reads go first until a flush request, which drains every write.
 */

`timescale 1ns/100ps

module request_scheduler #(
    parameter int DATA_W = 64
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  dram_cmd_pkg::dram_cmd_t  i_rd_head,
    input  logic                    i_rd_empty,
    input  dram_cmd_pkg::dram_cmd_t  i_wr_head,
    input  logic [DATA_W-1:0]       i_wr_head_wdata,
    input  logic                    i_wr_empty,
    input  logic                    i_flush_req,
    input  gc_sched_pkg::bank_mask_t i_bank_ready,
    output logic                    o_rd_pop,
    output logic                    o_wr_pop,
    output logic                    o_flushing,
    output logic                    o_issue_valid,
    output dram_cmd_pkg::dram_cmd_t  o_issue_cmd,
    output logic [DATA_W-1:0]       o_issue_wdata
);

    gc_sched_pkg::sched_mode_e mode_q;
    gc_sched_pkg::sched_mode_e mode_d;
    logic                      sel_wr;
    logic                      head_valid;
    logic                      pop;
    dram_cmd_pkg::dram_cmd_t   head;

    ////////////////////////////////////////////////////////////
    // mode FSM
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        mode_d = mode_q;
        case (mode_q)
            gc_sched_pkg::READ_FIRST:
            begin
                if (i_flush_req)
                begin
                    mode_d = gc_sched_pkg::WRITE_FLUSH;
                end
            end
            default:
            begin
                // back to reads once the buffer is drained
                if (i_wr_empty)
                begin
                    mode_d = gc_sched_pkg::READ_FIRST;
                end
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            mode_q <= gc_sched_pkg::READ_FIRST;
        end
        else
        begin
            mode_q <= mode_d;
        end
    end

    // a blocked head is never bypassed
    assign sel_wr     = (mode_q == gc_sched_pkg::WRITE_FLUSH) || i_rd_empty;
    assign head       = sel_wr ? i_wr_head : i_rd_head;
    assign head_valid = sel_wr ? !i_wr_empty : !i_rd_empty;
    assign pop        = head_valid && i_bank_ready[head.bank];

    assign o_rd_pop   = pop && !sel_wr;
    assign o_wr_pop   = pop && sel_wr;
    assign o_flushing = (mode_q == gc_sched_pkg::WRITE_FLUSH);

    ////////////////////////////////////////////////////////////
    // issue register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_issue_valid <= 1'b0;
        end
        else
        begin
            o_issue_valid <= pop;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (pop)
        begin
            o_issue_cmd <= head;
        end
        if (o_wr_pop)
        begin
            o_issue_wdata <= i_wr_head_wdata;
        end
    end

    a_one_pop: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_rd_pop && o_wr_pop));

endmodule

//--- src/write_buffer.sv
/*
 * Write command and data queue with a read-after-write address check.
 * Requests a flush at the fill watermark or after a hazard hit.
 */

`timescale 1ns/100ps

module write_buffer #(
    parameter int DEPTH       = 8,
    parameter int DATA_W      = 64,
    parameter int FLUSH_LEVEL = 4
) (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_push,
    input  dram_cmd_pkg::dram_cmd_t  i_cmd,
    input  logic [DATA_W-1:0]       i_wdata,
    input  logic                    i_read_probe,
    input  dram_cmd_pkg::dram_addr_t i_probe_addr,
    input  logic                    i_pop,
    output dram_cmd_pkg::dram_cmd_t  o_head,
    output logic [DATA_W-1:0]       o_head_wdata,
    output logic                    o_empty,
    output logic                    o_full,
    output logic                    o_flush_req
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    dram_cmd_pkg::dram_cmd_t cmd_mem  [DEPTH];
    logic [DATA_W-1:0]       data_mem [DEPTH];
    logic [DEPTH-1:0]        slot_valid_q;
    logic [PTR_W-1:0]        rd_ptr_q;
    logic [PTR_W-1:0]        wr_ptr_q;
    logic [CNT_W-1:0]        count_q;
    logic [CNT_W-1:0]        count_d;
    logic                    hit;
    logic                    hazard_q;

    always_ff @(posedge i_clk)
    begin
        if (i_push)
        begin
            cmd_mem[wr_ptr_q]  <= i_cmd;
            data_mem[wr_ptr_q] <= i_wdata;
        end
    end

    assign count_d = count_q + CNT_W'(i_push) - CNT_W'(i_pop);

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            slot_valid_q <= '0;
            rd_ptr_q     <= '0;
            wr_ptr_q     <= '0;
            count_q      <= '0;
        end
        else
        begin
            if (i_push)
            begin
                slot_valid_q[wr_ptr_q] <= 1'b1;
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (i_pop)
            begin
                slot_valid_q[rd_ptr_q] <= 1'b0;
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // hazard compare against every pending write
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        hit = 1'b0;
        for (int i = 0; i < DEPTH; i++)
        begin
            if (slot_valid_q[i] &&
                {cmd_mem[i].bank, cmd_mem[i].row, cmd_mem[i].col} == i_probe_addr)
            begin
                hit = 1'b1;
            end
        end
        hit = hit && i_read_probe;
    end

    // sticky until the last pending write leaves
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            hazard_q <= 1'b0;
        end
        else if (count_d == '0)
        begin
            hazard_q <= 1'b0;
        end
        else if (hit)
        begin
            hazard_q <= 1'b1;
        end
    end

    assign o_head       = cmd_mem[rd_ptr_q];
    assign o_head_wdata = data_mem[rd_ptr_q];
    assign o_empty      = (count_q == '0);
    assign o_full       = (count_q == CNT_W'(DEPTH));
    // hit counts in its own cycle so the read cannot be picked next
    assign o_flush_req  = hit || hazard_q || (count_q >= CNT_W'(FLUSH_LEVEL));

    a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_push |-> !o_full);
    a_no_flush_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_empty |-> !o_flush_req);

endmodule

//--- tb/gc_vectors.txt
# R op bank row col wdata ready : request, bank ready mask held while it is offered
# E bank op row col wdata       : expected dispatch, in order of arrival
# D release ready               : end of test, release f = fixed ready mask, 1b = random
#                                 with bank b blocked, ready = o_req_ready once settled
R 1 1 0011 011 1111000000000001 0
R 0 2 0022 022 0 0
R 1 3 0033 033 3333000000000003 0
R 0 0 0044 044 0 0
E 2 0 0022 022 0
E 0 0 0044 044 0
E 1 1 0011 011 1111000000000001
E 3 1 0033 033 3333000000000003
D f 1
R 1 0 0101 101 a0a0000000000101 0
R 1 0 0102 102 a0a0000000000102 0
R 0 0 0103 103 0 0
R 0 1 0104 104 0 0
R 1 2 0105 105 a0a0000000000105 0
E 0 0 0103 103 0
E 1 0 0104 104 0
E 0 1 0101 101 a0a0000000000101
E 0 1 0102 102 a0a0000000000102
E 2 1 0105 105 a0a0000000000105
D f 1
R 0 1 0201 201 0 0
R 1 0 0202 202 b0b0000000000202 0
R 1 1 0203 203 b0b0000000000203 0
R 1 2 0204 204 b0b0000000000204 0
R 1 3 0205 205 b0b0000000000205 0
E 0 1 0202 202 b0b0000000000202
E 1 1 0203 203 b0b0000000000203
E 2 1 0204 204 b0b0000000000204
E 3 1 0205 205 b0b0000000000205
E 1 0 0201 201 0
D f 0
R 0 3 0301 301 0 0
R 1 1 0302 302 c0c0000000000302 0
R 1 2 0303 303 c0c0000000000303 0
R 0 1 0302 302 0 0
E 1 1 0302 302 c0c0000000000302
E 2 1 0303 303 c0c0000000000303
E 3 0 0301 301 0
E 1 0 0302 302 0
D f 0
R 0 2 0401 041 0 0
R 1 2 0402 042 d0d0000000000402 0
R 0 0 0403 043 0 0
R 1 1 0404 044 d0d0000000000404 0
R 0 2 0405 045 0 0
R 1 3 0406 046 d0d0000000000406 0
E 2 0 0401 041 0
E 0 0 0403 043 0
E 2 0 0405 045 0
E 2 1 0402 042 d0d0000000000402
E 1 1 0404 044 d0d0000000000404
E 3 1 0406 046 d0d0000000000406
D 12 1

//--- tb/tb_global_controller.sv
/*
 * Testbench for the global controller front end.
 * Replays the requests of tb/gc_vectors.txt test by test and checks
 * every bank dispatch against the expected stream of that test.
 */

`timescale 1ns/100ps

module tb_global_controller;

    localparam int    DATA_W         = 64;
    localparam int    HALF_PERIOD    = 2;
    localparam int    RESET_CYCLES   = 8;
    localparam int    SETTLE_CYCLES  = 4;
    localparam int    IDLE_CYCLES    = 8;
    localparam int    BLOCK_CYCLES   = 20;
    localparam int    CYCLES_PER_VEC = 40;
    localparam int    SEED           = 32'h27f1;
    localparam string VEC_FILE       = "tb/gc_vectors.txt";

    // one record of the vector file
    typedef struct packed {
        logic [7:0]              kind;
        dram_cmd_pkg::dram_cmd_t cmd;
        logic [DATA_W-1:0]       data;
        logic [7:0]              mask;
        logic                    ready;
    } vec_rec_t;

    logic                     i_clk;
    logic                     i_rst_n;
    logic                     i_req_valid;
    dram_cmd_pkg::dram_cmd_t  i_req_cmd;
    logic [DATA_W-1:0]        i_req_wdata;
    logic                     o_req_ready;
    gc_sched_pkg::bank_mask_t i_bank_ready;
    gc_sched_pkg::bank_mask_t o_bank_valid;
    dram_cmd_pkg::dram_cmd_t  o_bank_cmd;
    logic [DATA_W-1:0]        o_bank_wdata;

    vec_rec_t recs[$];
    vec_rec_t exp_q[$];
    int       err_count = 0;
    int       n_checked = 0;
    int       n_vectors = 0;
    logic     load_done = 1'b0;

    global_controller #(
        .DATA_W(DATA_W), .RD_DEPTH(8), .WR_DEPTH(8), .FLUSH_LEVEL(4)
    ) dut (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_req_valid(i_req_valid), .i_req_cmd(i_req_cmd),
        .i_req_wdata(i_req_wdata), .o_req_ready(o_req_ready),
        .i_bank_ready(i_bank_ready), .o_bank_valid(o_bank_valid),
        .o_bank_cmd(o_bank_cmd), .o_bank_wdata(o_bank_wdata)
    );

    always #(HALF_PERIOD) i_clk = ~i_clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    task automatic load_vectors(output bit ok);
        int          fd;
        string       line;
        logic [7:0]  kind;
        logic [63:0] a, b, c, d, e, f;
        vec_rec_t    r;
        ok = 1'b0;
        fd = $fopen(VEC_FILE, "r");
        if (fd != 0)
        begin
            ok = 1'b1;
            while ($fgets(line, fd) != 0)
            begin
                if (line.len() > 1 && line.getc(0) != "#")
                begin
                    {a, b, c, d, e, f} = '0;
                    void'($sscanf(line, "%c %h %h %h %h %h %h", kind, a, b, c, d, e, f));
                    r = '0;
                    r.kind = kind;
                    // expected records name the bank first
                    r.cmd.op   = (kind == "E") ? b[0] : a[0];
                    r.cmd.bank = (kind == "E") ? a[1:0] : b[1:0];
                    r.cmd.row  = c[dram_cmd_pkg::ROW_W-1:0];
                    r.cmd.col  = d[dram_cmd_pkg::COL_W-1:0];
                    r.data     = e;
                    r.mask     = (kind == "D") ? a[7:0] : f[7:0];
                    r.ready    = b[0];
                    if (kind != "D")
                    begin
                        n_vectors++;
                    end
                    recs.push_back(r);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("[ERROR] %s expected 0x%h got 0x%h", name, expected, actual);
        err_count++;
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        err_count++;
    endtask

    // holds the request until the handshake completes
    task automatic offer_request(input vec_rec_t r);
        bit accepted;
        accepted = 1'b0;
        @(posedge i_clk);
        i_req_valid  <= 1'b1;
        i_req_cmd    <= r.cmd;
        i_req_wdata  <= r.data;
        i_bank_ready <= r.mask[dram_cmd_pkg::NUM_BANKS-1:0];
        while (!accepted)
        begin
            @(negedge i_clk);
            accepted = o_req_ready;
            @(posedge i_clk);
        end
        i_req_valid <= 1'b0;
    endtask

    // bit 4 of the release value selects random readies
    task automatic drain_dispatches(input logic [7:0] release_mode);
        int                       block_left;
        logic [31:0]              rnd;
        gc_sched_pkg::bank_mask_t mask;
        block_left = BLOCK_CYCLES;
        while (exp_q.size() != 0)
        begin
            @(posedge i_clk);
            if (release_mode[4])
            begin
                rnd  = $urandom;
                mask = rnd[dram_cmd_pkg::NUM_BANKS-1:0];
                // one bank stays blocked for a stretch
                if (block_left > 0)
                begin
                    mask[release_mode[1:0]] = 1'b0;
                    block_left--;
                end
                i_bank_ready <= mask;
            end
            else
            begin
                i_bank_ready <= release_mode[dram_cmd_pkg::NUM_BANKS-1:0];
            end
        end
    endtask

    task automatic check_dispatch(input vec_rec_t e);
        gc_sched_pkg::bank_mask_t want;
        want = gc_sched_pkg::bank_mask_t'(1) << e.cmd.bank;
        n_checked++;
        assert (o_bank_valid == want)
            else report_mismatch("o_bank_valid", 64'(want), 64'(o_bank_valid));
        assert (o_bank_cmd.op == e.cmd.op)
            else report_mismatch("o_bank_cmd.op", 64'(e.cmd.op), 64'(o_bank_cmd.op));
        assert (o_bank_cmd.bank == e.cmd.bank)
            else report_mismatch("o_bank_cmd.bank", 64'(e.cmd.bank), 64'(o_bank_cmd.bank));
        assert (o_bank_cmd.row == e.cmd.row)
            else report_mismatch("o_bank_cmd.row", 64'(e.cmd.row), 64'(o_bank_cmd.row));
        assert (o_bank_cmd.col == e.cmd.col)
            else report_mismatch("o_bank_cmd.col", 64'(e.cmd.col), 64'(o_bank_cmd.col));
        // data only rides along with writes
        if (e.cmd.op == dram_cmd_pkg::OP_WRITE)
        begin
            assert (o_bank_wdata == e.data)
                else report_mismatch("o_bank_wdata", e.data, o_bank_wdata);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // dispatch monitor on the falling edge
    ////////////////////////////////////////////////////////////
    always @(negedge i_clk)
    begin : monitor
        vec_rec_t e;
        if (i_rst_n && o_bank_valid != '0)
        begin
            assert (exp_q.size() != 0)
                else report_failure($sformatf(
                    "dispatch on bank mask 0x%h arrived when none was expected", o_bank_valid));
            if (exp_q.size() != 0)
            begin
                e = exp_q.pop_front();
                check_dispatch(e);
            end
        end
    end

    initial
    begin : watchdog
        wait (load_done);
        repeat (n_vectors * CYCLES_PER_VEC) @(posedge i_clk);
        $display("timeout: %0d dispatches still outstanding", exp_q.size());
        $display("Finished with errors");
        $finish;
    end

    initial
    begin : main
        bit       ok;
        int       idx;
        int       test_no;
        int       errs_before;
        int       n_exp;
        vec_rec_t req_q[$];
        vec_rec_t r;

        i_clk        = 1'b0;
        i_rst_n      = 1'b0;
        i_req_valid  = 1'b0;
        i_req_cmd    = '0;
        i_req_wdata  = '0;
        i_bank_ready = '0;
        void'($urandom(SEED));
        load_vectors(ok);
        if (!ok)
        begin
            $display("vector file %s could not be opened", VEC_FILE);
            $display("Finished with errors");
            $finish;
        end
        else
        begin
            load_done = 1'b1;
            repeat (RESET_CYCLES) @(posedge i_clk);
            i_rst_n <= 1'b1;
            @(negedge i_clk);
            assert (o_bank_valid == '0)
                else report_mismatch("o_bank_valid", 64'(0), 64'(o_bank_valid));
            assert (o_req_ready == 1'b1)
                else report_mismatch("o_req_ready", 64'(1), 64'(o_req_ready));
            $display("test 0 reset: %s", (err_count == 0) ? "passed" : "failed");
            idx     = 0;
            test_no = 0;
            while (idx < recs.size())
            begin
                test_no++;
                errs_before = err_count;
                req_q.delete();
                // gather one test up to its closing record
                while (idx < recs.size() && recs[idx].kind != "D")
                begin
                    if (recs[idx].kind == "R")
                    begin
                        req_q.push_back(recs[idx]);
                    end
                    else
                    begin
                        exp_q.push_back(recs[idx]);
                    end
                    idx++;
                end
                n_exp = exp_q.size();
                r     = recs[idx];
                idx++;
                foreach (req_q[i])
                begin
                    offer_request(req_q[i]);
                end
                repeat (SETTLE_CYCLES) @(posedge i_clk);
                @(negedge i_clk);
                assert (o_req_ready == r.ready)
                    else report_mismatch("o_req_ready", 64'(r.ready), 64'(o_req_ready));
                drain_dispatches(r.mask);
                repeat (IDLE_CYCLES) @(posedge i_clk);
                @(negedge i_clk);
                assert (o_req_ready == 1'b1)
                    else report_mismatch("o_req_ready", 64'(1), 64'(o_req_ready));
                $display("test %0d: %0d requests, %0d dispatches, %s", test_no, req_q.size(),
                         n_exp, (err_count == errs_before) ? "passed" : "failed");
            end
            $display("%0d tests, %0d dispatches checked, %0d errors",
                     test_no, n_checked, err_count);
            if (err_count == 0)
            begin
                $display("Finished with no errors");
            end
            else
            begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

endmodule
